// File: motor_regs_pkg.sv
// Register map for the swerve motor controller host interface
// Shared by the channel register blocks, the top level and the testbench

package motor_regs_pkg;

    // Bus and field widths
    localparam int ADDR_W  = 6;   // 64 byte address space
    localparam int DATA_W  = 8;
    localparam int PWM_W   = 5;   // Drive PWM duty
    localparam int TEMP_W  = 6;   // ADC temperature code
    localparam int ANGLE_W = 12;  // Rotation angle
    localparam int KP_W    = 8;   // Kp, fixed point 4.4
    localparam int KI_W    = 4;   // Ki, fixed point 0.4
    localparam int KD_W    = 4;   // Kd, fixed point 0.4

    // Default channel counts
    localparam int NUM_DRIVE = 4;
    localparam int NUM_ROT   = 4;

    // 0x00 reserved, writes dropped
    localparam logic [ADDR_W-1:0] ADDR_BCAST_ALL   = 6'h01;  // All PWM modules
    // 0x02 rotation broadcast, reserved and has no effect
    localparam logic [ADDR_W-1:0] ADDR_BCAST_DRIVE = 6'h03;  // All drive modules

    // Drive channels, control at base and status at base+1
    localparam logic [ADDR_W-1:0] DRIVE_BASE   = 6'h04;
    localparam int                DRIVE_STRIDE = 2;

    // Rotation channels, 7 bytes each starting at 0x0C
    localparam logic [ADDR_W-1:0] ROT_BASE   = 6'h0C;
    localparam int                ROT_STRIDE = 7;

    // Offsets inside one rotation channel
    localparam logic [ADDR_W-1:0] ROT_OFS_CTRL     = 6'd0;  // Enables, target[11:8]
    localparam logic [ADDR_W-1:0] ROT_OFS_TARGET   = 6'd1;  // Target[7:0]
    localparam logic [ADDR_W-1:0] ROT_OFS_ANGLE_LO = 6'd2;  // Snapshot[7:0]
    localparam logic [ADDR_W-1:0] ROT_OFS_CMD      = 6'd3;  // Command / status
    localparam logic [ADDR_W-1:0] ROT_OFS_KP       = 6'd4;
    localparam logic [ADDR_W-1:0] ROT_OFS_KIKD     = 6'd5;  // Ki high nibble, Kd low
    // Offset 6 was the PWM override byte, now reads zero

    // Command byte as written by the host
    typedef struct packed {
        logic       unused_hi;  // Bit 7, ignored
        logic       snapshot;   // Capture current angle
        logic       update;     // Start move to target
        logic       abort;      // Stop the move
        logic [3:0] unused_lo;  // Ignored
    } rot_cmd_wr_t;

    // Same byte as returned on a read
    typedef struct packed {
        logic       done;       // Arrived at target
        logic [2:0] zero;
        logic [3:0] snap_hi;    // Snapshot[11:8]
    } rot_cmd_rd_t;

    // One address, two meanings depending on direction
    typedef union packed {
        rot_cmd_wr_t cmd;
        rot_cmd_rd_t status;
    } rot_cmd_u;

endpackage

// File: drive_channel_regs.sv
// Control and status bytes of one drive motor
// Instantiated per drive channel by the register file top level

`timescale 1ns/10ps

module drive_channel_regs #(
    parameter logic [motor_regs_pkg::ADDR_W-1:0] BASE_ADDR = motor_regs_pkg::DRIVE_BASE
) (
    input  logic                                clock,
    input  logic                                rst_n,
    input  logic [motor_regs_pkg::ADDR_W-1:0]   address,
    input  logic                                write_en,
    input  logic [motor_regs_pkg::DATA_W-1:0]   wr_data,
    input  logic                                fault,     // Driver fault flag
    input  logic                                stall,     // Motor stalled
    input  logic [motor_regs_pkg::TEMP_W-1:0]   adc_temp,  // Temperature code
    output logic                                brake,
    output logic                                enable,
    output logic                                direction,
    output logic [motor_regs_pkg::PWM_W-1:0]    pwm,
    output logic [motor_regs_pkg::DATA_W-1:0]   rd_byte    // Zero when not addressed
);
    import motor_regs_pkg::*;

    localparam logic [ADDR_W-1:0] CTRL_ADDR = BASE_ADDR;
    localparam logic [ADDR_W-1:0] STAT_ADDR = BASE_ADDR + ADDR_W'(1);

    logic [DATA_W-1:0] ctrl_q;    // brake, enable, direction, pwm[4:0]
    logic [DATA_W-1:0] status_q;  // fault, stall, temp[5:0]
    logic              ctrl_we;

    // Own address or either broadcast hits the control byte
    assign ctrl_we = write_en &&
                     ((address == CTRL_ADDR) ||
                      (address == ADDR_BCAST_ALL) ||
                      (address == ADDR_BCAST_DRIVE));

    always_ff @(posedge clock or negedge rst_n) begin
        if (!rst_n) begin
            ctrl_q <= '0;  // Motor off, brake released
        end else if (ctrl_we) begin
            ctrl_q <= wr_data;
        end
    end

    // Status sampled every clock, a read sees last cycle's inputs
    always_ff @(posedge clock) begin
        status_q <= {fault, stall, adc_temp};
    end

    // Field breakout
    assign brake     = ctrl_q[7];
    assign enable    = ctrl_q[6];
    assign direction = ctrl_q[5];
    assign pwm       = ctrl_q[PWM_W-1:0];

    // Readback mux for this channel's two bytes
    always_comb begin
        case (address)
            CTRL_ADDR: rd_byte = ctrl_q;
            STAT_ADDR: rd_byte = status_q;
            default:   rd_byte = '0;  // Another channel's byte
        endcase
    end

endmodule

// File: rotation_channel_regs.sv
// Target angle, PID gain and command registers of one rotation motor
// Command writes pulse update/abort and snapshot the current angle

`timescale 1ns/10ps

module rotation_channel_regs #(
    parameter logic [motor_regs_pkg::ADDR_W-1:0] BASE_ADDR = motor_regs_pkg::ROT_BASE
) (
    input  logic                                clock,
    input  logic                                rst_n,
    input  logic [motor_regs_pkg::ADDR_W-1:0]   address,
    input  logic                                write_en,
    input  logic [motor_regs_pkg::DATA_W-1:0]   wr_data,
    input  logic [motor_regs_pkg::ANGLE_W-1:0]  current_angle,  // From the position sensor
    input  logic                                angle_done,     // Move finished
    output logic                                rot_enable,
    output logic                                enable_stall_chk,
    output logic [motor_regs_pkg::ANGLE_W-1:0]  target_angle,
    output logic [motor_regs_pkg::KP_W-1:0]     kp,             // 4.4
    output logic [motor_regs_pkg::KI_W-1:0]     ki,             // 0.4
    output logic [motor_regs_pkg::KD_W-1:0]     kd,             // 0.4
    output logic                                update_angle,   // One cycle pulse
    output logic                                abort_angle,    // One cycle pulse
    output logic [motor_regs_pkg::DATA_W-1:0]   rd_byte
);
    import motor_regs_pkg::*;

    // Absolute addresses of this channel's bytes
    localparam logic [ADDR_W-1:0] A_CTRL     = BASE_ADDR + ROT_OFS_CTRL;
    localparam logic [ADDR_W-1:0] A_TARGET   = BASE_ADDR + ROT_OFS_TARGET;
    localparam logic [ADDR_W-1:0] A_ANGLE_LO = BASE_ADDR + ROT_OFS_ANGLE_LO;
    localparam logic [ADDR_W-1:0] A_CMD      = BASE_ADDR + ROT_OFS_CMD;
    localparam logic [ADDR_W-1:0] A_KP       = BASE_ADDR + ROT_OFS_KP;
    localparam logic [ADDR_W-1:0] A_KIKD     = BASE_ADDR + ROT_OFS_KIKD;

    logic [DATA_W-1:0]  ctrl_q;       // Bit 4 always zero
    logic [DATA_W-1:0]  target_lo_q;  // target_angle[7:0]
    logic [KP_W-1:0]    kp_q;
    logic [DATA_W-1:0]  kikd_q;       // Ki in [7:4], Kd in [3:0]
    logic [ANGLE_W-1:0] snap_q;       // Coherent angle copy
    logic               update_q;
    logic               abort_q;
    logic               done_q;

    rot_cmd_u cmd_wr;  // Write view of wr_data
    rot_cmd_u cmd_rd;  // Read view built from status
    logic     cmd_we;

    assign cmd_wr = wr_data;
    assign cmd_we = write_en && (address == A_CMD);

    // Control fields, write at the edge
    always_ff @(posedge clock or negedge rst_n) begin
        if (!rst_n) begin
            ctrl_q      <= '0;
            target_lo_q <= '0;
            kp_q        <= '0;
            kikd_q      <= '0;
        end else if (write_en) begin
            case (address)
                // Old startup_fail bit is gone, keep it reserved
                A_CTRL:   ctrl_q      <= {wr_data[7:5], 1'b0, wr_data[3:0]};
                A_TARGET: target_lo_q <= wr_data;
                A_KP:     kp_q        <= wr_data;
                A_KIKD:   kikd_q      <= wr_data;
                default: ;  // Not ours, or read only
            endcase
        end
    end

    // Command byte decode
    always_ff @(posedge clock or negedge rst_n) begin
        if (!rst_n) begin
            update_q <= 1'b0;
            abort_q  <= 1'b0;
            snap_q   <= '0;
        end else begin
            // Pulses drop again the cycle after
            update_q <= cmd_we && cmd_wr.cmd.update;
            abort_q  <= cmd_we && cmd_wr.cmd.abort;
            // Snapshot so both bytes come from the same sample
            if (cmd_we && cmd_wr.cmd.snapshot) begin
                snap_q <= current_angle;
            end
        end
    end

    // Done flag sampled like drive status
    always_ff @(posedge clock) begin
        done_q <= angle_done;
    end

    always_comb begin
        cmd_rd                = '0;
        cmd_rd.status.done    = done_q;
        cmd_rd.status.snap_hi = snap_q[ANGLE_W-1:8];
    end

    // Outputs
    assign rot_enable       = ctrl_q[6];
    assign enable_stall_chk = ctrl_q[5];
    assign target_angle     = {ctrl_q[3:0], target_lo_q};
    assign kp               = kp_q;
    assign ki               = kikd_q[7:4];
    assign kd               = kikd_q[3:0];
    assign update_angle     = update_q;
    assign abort_angle      = abort_q;

    // Readback, override offset falls to default
    always_comb begin
        case (address)
            A_CTRL:     rd_byte = ctrl_q;
            A_TARGET:   rd_byte = target_lo_q;
            A_ANGLE_LO: rd_byte = snap_q[7:0];
            A_CMD:      rd_byte = cmd_rd;
            A_KP:       rd_byte = kp_q;
            A_KIKD:     rd_byte = kikd_q;
            default:    rd_byte = '0;
        endcase
    end

endmodule

// File: motor_reg_file.sv
// Host register file for the four corner swerve motor controller
// Builds the drive and rotation channel blocks and registers the read data

`timescale 1ns/10ps

module motor_reg_file #(
    parameter int NUM_DRIVE = motor_regs_pkg::NUM_DRIVE,
    parameter int NUM_ROT   = motor_regs_pkg::NUM_ROT
) (
    input  logic                                              clock,
    input  logic                                              rst_n,
    input  logic [motor_regs_pkg::ADDR_W-1:0]                 address,
    input  logic                                              write_en,
    input  logic [motor_regs_pkg::DATA_W-1:0]                 wr_data,
    input  logic                                              read_en,
    output logic [motor_regs_pkg::DATA_W-1:0]                 rd_data,

    // Drive motors
    input  logic [NUM_DRIVE-1:0]                              fault,
    input  logic [NUM_DRIVE-1:0]                              stall,
    input  logic [NUM_DRIVE-1:0][motor_regs_pkg::TEMP_W-1:0]  adc_temp,
    output logic [NUM_DRIVE-1:0]                              brake,
    output logic [NUM_DRIVE-1:0]                              enable,
    output logic [NUM_DRIVE-1:0]                              direction,
    output logic [NUM_DRIVE-1:0][motor_regs_pkg::PWM_W-1:0]   pwm,

    // Rotation motors
    input  logic [NUM_ROT-1:0][motor_regs_pkg::ANGLE_W-1:0]   current_angle,
    input  logic [NUM_ROT-1:0]                                angle_done,
    output logic [NUM_ROT-1:0]                                rot_enable,
    output logic [NUM_ROT-1:0]                                enable_stall_chk,
    output logic [NUM_ROT-1:0][motor_regs_pkg::ANGLE_W-1:0]   target_angle,
    output logic [NUM_ROT-1:0][motor_regs_pkg::KP_W-1:0]      kp,
    output logic [NUM_ROT-1:0][motor_regs_pkg::KI_W-1:0]      ki,
    output logic [NUM_ROT-1:0][motor_regs_pkg::KD_W-1:0]      kd,
    output logic [NUM_ROT-1:0]                                update_angle,
    output logic [NUM_ROT-1:0]                                abort_angle
);
    import motor_regs_pkg::*;

    logic [NUM_DRIVE-1:0][DATA_W-1:0] drive_rd;  // One byte per drive channel
    logic [NUM_ROT-1:0][DATA_W-1:0]   rot_rd;
    logic [DATA_W-1:0]                rd_mux;    // OR of all channels

    // Drive channels at 0x04, 0x06, ...
    for (genvar gi = 0; gi < NUM_DRIVE; gi++) begin : g_drive
        localparam logic [ADDR_W-1:0] D_BASE = ADDR_W'(DRIVE_BASE + gi * DRIVE_STRIDE);

        drive_channel_regs #(
            .BASE_ADDR (D_BASE)
        ) u_drive (
            .clock     (clock),
            .rst_n     (rst_n),
            .address   (address),
            .write_en  (write_en),
            .wr_data   (wr_data),
            .fault     (fault[gi]),
            .stall     (stall[gi]),
            .adc_temp  (adc_temp[gi]),
            .brake     (brake[gi]),
            .enable    (enable[gi]),
            .direction (direction[gi]),
            .pwm       (pwm[gi]),
            .rd_byte   (drive_rd[gi])
        );
    end

    // Rotation channels, 7 bytes apart from 0x0C
    for (genvar gi = 0; gi < NUM_ROT; gi++) begin : g_rot
        localparam logic [ADDR_W-1:0] R_BASE = ADDR_W'(ROT_BASE + gi * ROT_STRIDE);

        rotation_channel_regs #(
            .BASE_ADDR (R_BASE)
        ) u_rot (
            .clock            (clock),
            .rst_n            (rst_n),
            .address          (address),
            .write_en         (write_en),
            .wr_data          (wr_data),
            .current_angle    (current_angle[gi]),
            .angle_done       (angle_done[gi]),
            .rot_enable       (rot_enable[gi]),
            .enable_stall_chk (enable_stall_chk[gi]),
            .target_angle     (target_angle[gi]),
            .kp               (kp[gi]),
            .ki               (ki[gi]),
            .kd               (kd[gi]),
            .update_angle     (update_angle[gi]),
            .abort_angle      (abort_angle[gi]),
            .rd_byte          (rot_rd[gi])
        );
    end

    // Only the addressed channel drives a nonzero byte
    always_comb begin
        rd_mux = '0;
        for (int i = 0; i < NUM_DRIVE; i++) begin
            rd_mux = rd_mux | drive_rd[i];
        end
        for (int i = 0; i < NUM_ROT; i++) begin
            rd_mux = rd_mux | rot_rd[i];
        end
    end

    // Read data held until the next read
    always_ff @(posedge clock or negedge rst_n) begin
        if (!rst_n) begin
            rd_data <= '0;
        end else if (read_en) begin
            rd_data <= rd_mux;  // Pre-write value on a same-cycle write
        end
    end

endmodule

// File: tb_motor_reg_model.svh
// Reference model of the motor register map, included inside the testbench module
// Shadow bytes follow host writes and the functions give expected values

`ifndef TB_MOTOR_REG_MODEL_SVH
`define TB_MOTOR_REG_MODEL_SVH

logic [DATA_W-1:0]  shadow [0:63];             // Expected control byte per address
logic [ANGLE_W-1:0] snap_model [0:NUM_ROT-1];  // Angle held by the last snapshot
logic [NUM_ROT-1:0] upd_exp;                   // Pulses due in the current cycle
logic [NUM_ROT-1:0] abt_exp;

// Drive channel owning an address, or -1
function automatic int drive_chan(input int a);
    int rel;
    rel = a - int'(DRIVE_BASE);
    if (rel >= 0 && rel < NUM_DRIVE * DRIVE_STRIDE) begin
        return rel / DRIVE_STRIDE;
    end
    return -1;
endfunction

// Rotation channel owning an address, or -1
function automatic int rot_chan(input int a);
    int rel;
    rel = a - int'(ROT_BASE);
    if (rel >= 0 && rel < NUM_ROT * ROT_STRIDE) begin
        return rel / ROT_STRIDE;
    end
    return -1;
endfunction

function automatic int rot_ofs(input int a);
    return (a - int'(ROT_BASE)) % ROT_STRIDE;
endfunction

function automatic void model_reset();
    for (int a = 0; a < 64; a++) begin
        shadow[a] = '0;
    end
    for (int ch = 0; ch < NUM_ROT; ch++) begin
        snap_model[ch] = '0;
    end
    upd_exp = '0;
    abt_exp = '0;
endfunction

// Host write as the register map defines it
function automatic void model_write(input int a, input logic [DATA_W-1:0] d);
    int ch;
    ch = rot_chan(a);
    if (a == int'(ADDR_BCAST_ALL) || a == int'(ADDR_BCAST_DRIVE)) begin
        for (int i = 0; i < NUM_DRIVE; i++) begin
            shadow[int'(DRIVE_BASE) + i * DRIVE_STRIDE] = d;  // Drive controls only
        end
    end else if (drive_chan(a) >= 0) begin
        if ((a - int'(DRIVE_BASE)) % DRIVE_STRIDE == 0) begin
            shadow[a] = d;  // Status byte is read only
        end
    end else if (ch >= 0) begin
        case (rot_ofs(a))
            ROT_OFS_CTRL: shadow[a] = d & 8'hEF;  // Bit 4 reserved
            ROT_OFS_TARGET, ROT_OFS_KP, ROT_OFS_KIKD: shadow[a] = d;
            ROT_OFS_CMD: begin
                upd_exp[ch] = d[5];
                abt_exp[ch] = d[4];
                if (d[6]) begin
                    snap_model[ch] = current_angle[ch];  // Angle at the write edge
                end
            end
            default: ;  // Angle byte read only, override dropped
        endcase
    end
    // 0x00 and 0x02 have no effect
endfunction

function automatic logic [DATA_W-1:0] exp_status(input logic f, input logic s,
                                                 input logic [TEMP_W-1:0] t);
    return {f, s, t};
endfunction

function automatic logic [DATA_W-1:0] exp_cmd_status(input logic done,
                                                     input logic [ANGLE_W-1:0] snap);
    return {done, 3'b000, snap[11:8]};
endfunction

function automatic logic [DATA_W-1:0] exp_drive_ctrl(input int ch);
    return shadow[int'(DRIVE_BASE) + ch * DRIVE_STRIDE];
endfunction

function automatic logic [DATA_W-1:0] exp_rot_ctrl(input int ch);
    return shadow[int'(ROT_BASE) + ch * ROT_STRIDE + int'(ROT_OFS_CTRL)];
endfunction

function automatic logic [ANGLE_W-1:0] exp_target(input int ch);
    int b;
    b = int'(ROT_BASE) + ch * ROT_STRIDE;
    return {shadow[b + int'(ROT_OFS_CTRL)][3:0], shadow[b + int'(ROT_OFS_TARGET)]};
endfunction

// Kp, then Ki and Kd
function automatic logic [15:0] exp_gains(input int ch);
    int b;
    b = int'(ROT_BASE) + ch * ROT_STRIDE;
    return {shadow[b + int'(ROT_OFS_KP)], shadow[b + int'(ROT_OFS_KIKD)]};
endfunction

// Byte a read of this address should return
function automatic logic [DATA_W-1:0] exp_read(input int a);
    int dc;
    int rc;
    logic [DATA_W-1:0] r;
    dc = drive_chan(a);
    rc = rot_chan(a);
    r  = '0;
    if (dc >= 0) begin
        if ((a - int'(DRIVE_BASE)) % DRIVE_STRIDE == 0) begin
            r = shadow[a];
        end else begin
            r = exp_status(fault[dc], stall[dc], adc_temp[dc]);
        end
    end else if (rc >= 0) begin
        case (rot_ofs(a))
            ROT_OFS_ANGLE_LO: r = snap_model[rc][7:0];
            ROT_OFS_CMD:      r = exp_cmd_status(angle_done[rc], snap_model[rc]);
            default:          r = shadow[a];  // Override offset stays zero
        endcase
    end
    return r;
endfunction

`endif

// File: tb_motor_reg_file.sv
// Testbench for the motor register file
// Random host writes and reads checked against the included register model

`timescale 1ns/10ps

module tb_motor_reg_file;
    import motor_regs_pkg::*;

    localparam int MAX_CYCLES = 20000;  // Whole run needs well under 2000 cycles

    logic                              clock;
    logic                              rst_n;
    logic [ADDR_W-1:0]                 address;
    logic                              write_en;
    logic [DATA_W-1:0]                 wr_data;
    logic                              read_en;
    logic [DATA_W-1:0]                 rd_data;
    logic [NUM_DRIVE-1:0]              fault;
    logic [NUM_DRIVE-1:0]              stall;
    logic [NUM_DRIVE-1:0][TEMP_W-1:0]  adc_temp;
    logic [NUM_DRIVE-1:0]              brake;
    logic [NUM_DRIVE-1:0]              enable;
    logic [NUM_DRIVE-1:0]              direction;
    logic [NUM_DRIVE-1:0][PWM_W-1:0]   pwm;
    logic [NUM_ROT-1:0][ANGLE_W-1:0]   current_angle;
    logic [NUM_ROT-1:0]                angle_done;
    logic [NUM_ROT-1:0]                rot_enable;
    logic [NUM_ROT-1:0]                enable_stall_chk;
    logic [NUM_ROT-1:0][ANGLE_W-1:0]   target_angle;
    logic [NUM_ROT-1:0][KP_W-1:0]      kp;
    logic [NUM_ROT-1:0][KI_W-1:0]      ki;
    logic [NUM_ROT-1:0][KD_W-1:0]      kd;
    logic [NUM_ROT-1:0]                update_angle;
    logic [NUM_ROT-1:0]                abort_angle;

    int seed        = 34721;
    int cycle_count = 0;
    bit checking    = 0;  // Output compare on after reset
    logic [DATA_W-1:0] rd_exp;  // Byte rd_data holds since the last read

    `include "tb_motor_reg_model.svh"

    // Same names on both sides
    motor_reg_file dut0 (.*);

    initial begin
        clock = 1'b0;
        forever #4 clock = ~clock;  // 8 ns period
    end

    always @(posedge clock) begin
        cycle_count <= cycle_count + 1;
        if (cycle_count >= MAX_CYCLES) begin
            $display("Timeout: run passed %0d cycles without finishing", MAX_CYCLES);
            $display("TEST FAILED");
            $fatal(1, "Simulation stopped by cycle limit");
        end
    end

    task automatic check_value(input logic [31:0] actual, input logic [31:0] expected,
                               input string what);
        if (actual !== expected) begin
            $display("Error at %0t ns: %s, got 0x%0h expected 0x%0h",
                     $time, what, actual, expected);
            $display("TEST FAILED");
            $fatal(1, "Stopping at first mismatch");
        end
    endtask

    // Outputs stable away from the rising edge
    always @(negedge clock) begin
        if (checking) begin
            compare_outputs();
        end
    end

    task automatic compare_outputs();
        logic [DATA_W-1:0] c;
        check_value(rd_data, rd_exp, "rd_data held since the last read");
        for (int ch = 0; ch < NUM_DRIVE; ch++) begin
            c = exp_drive_ctrl(ch);
            check_value(brake[ch], c[7], $sformatf("brake of drive %0d", ch));
            check_value(enable[ch], c[6], $sformatf("enable of drive %0d", ch));
            check_value(direction[ch], c[5], $sformatf("direction of drive %0d", ch));
            check_value(pwm[ch], c[4:0], $sformatf("pwm of drive %0d", ch));
        end
        for (int ch = 0; ch < NUM_ROT; ch++) begin
            c = exp_rot_ctrl(ch);
            check_value(rot_enable[ch], c[6], $sformatf("rot_enable %0d", ch));
            check_value(enable_stall_chk[ch], c[5], $sformatf("enable_stall_chk %0d", ch));
            check_value(target_angle[ch], exp_target(ch), $sformatf("target_angle %0d", ch));
            check_value({kp[ch], ki[ch], kd[ch]}, exp_gains(ch), $sformatf("gains %0d", ch));
            check_value(update_angle[ch], upd_exp[ch], $sformatf("update_angle %0d", ch));
            check_value(abort_angle[ch], abt_exp[ch], $sformatf("abort_angle %0d", ch));
        end
    endtask

    // One clock with inputs changed 1 ns after the edge
    task automatic tick();
        @(posedge clock);
        #1;
        upd_exp = '0;  // Pulses last one cycle
        abt_exp = '0;
    endtask

    task automatic write_reg(input int a, input logic [DATA_W-1:0] d);
        address  = ADDR_W'(a);
        wr_data  = d;
        write_en = 1'b1;
        tick();
        write_en = 1'b0;
        model_write(a, d);
    endtask

    task automatic read_check(input int a);
        logic [DATA_W-1:0] e;
        e        = exp_read(a);  // State before the read edge
        address  = ADDR_W'(a);
        read_en  = 1'b1;
        tick();
        read_en  = 1'b0;
        rd_exp   = e;
        check_value(rd_data, e, $sformatf("read of address 0x%02h", a));
    endtask

    task automatic read_all();
        for (int a = 0; a < 64; a++) begin
            read_check(a);
        end
    endtask

    initial begin
        logic [31:0] r;
        int          b;
        rst_n = 1'b0;
        address = '0;
        write_en = 1'b0;
        wr_data = '0;
        read_en = 1'b0;
        fault = '0;
        stall = '0;
        adc_temp = '0;
        current_angle = '0;
        angle_done = '0;
        rd_exp = '0;
        model_reset();
        repeat (8) @(posedge clock);
        #1 rst_n = 1'b1;
        checking = 1'b1;

        // Reset state
        check_value(rd_data, 0, "rd_data after reset");
        read_all();

        // Drive control bytes
        for (int n = 0; n < 8; n++) begin
            for (int ch = 0; ch < NUM_DRIVE; ch++) begin
                r = $random(seed);
                write_reg(int'(DRIVE_BASE) + ch * DRIVE_STRIDE, r[7:0]);
                read_check(int'(DRIVE_BASE) + ch * DRIVE_STRIDE);
            end
        end

        // Broadcasts must leave rotation bytes alone
        for (int ch = 0; ch < NUM_ROT; ch++) begin
            r = $random(seed);
            write_reg(int'(ROT_BASE) + ch * ROT_STRIDE + int'(ROT_OFS_KP), r[7:0]);
        end
        r = $random(seed);
        write_reg(ADDR_BCAST_ALL, r[7:0]);
        read_all();
        r = $random(seed);
        write_reg(ADDR_BCAST_DRIVE, r[7:0]);
        read_all();
        write_reg(0, 8'hFF);  // Reserved
        write_reg(2, 8'hFF);  // Unimplemented rotation broadcast
        for (int ch = 0; ch < NUM_ROT; ch++) begin
            write_reg(int'(ROT_BASE) + ch * ROT_STRIDE + 6, 8'hFF);  // Old override
        end
        read_all();

        // Drive status with inputs held two cycles before the read
        for (int n = 0; n < 8; n++) begin
            r = $random(seed);
            fault = r[NUM_DRIVE-1:0];
            stall = r[2*NUM_DRIVE-1:NUM_DRIVE];
            for (int ch = 0; ch < NUM_DRIVE; ch++) begin
                r = $random(seed);
                adc_temp[ch] = r[TEMP_W-1:0];
            end
            tick();
            for (int ch = 0; ch < NUM_DRIVE; ch++) begin
                read_check(int'(DRIVE_BASE) + ch * DRIVE_STRIDE + 1);
            end
        end

        // Rotation control, target and gains
        for (int n = 0; n < 6; n++) begin
            for (int ch = 0; ch < NUM_ROT; ch++) begin
                b = int'(ROT_BASE) + ch * ROT_STRIDE;
                for (int ofs = 0; ofs < 6; ofs++) begin
                    if (ofs != int'(ROT_OFS_ANGLE_LO) && ofs != int'(ROT_OFS_CMD)) begin
                        r = $random(seed);
                        write_reg(b + ofs, r[7:0]);
                        read_check(b + ofs);
                    end
                end
            end
        end

        // Command pulses, snapshot and done flag
        for (int n = 0; n < 8; n++) begin
            for (int ch = 0; ch < NUM_ROT; ch++) begin
                r = $random(seed);
                current_angle[ch] = r[ANGLE_W-1:0];
                angle_done[ch] = r[31];
            end
            tick();
            for (int ch = 0; ch < NUM_ROT; ch++) begin
                b = int'(ROT_BASE) + ch * ROT_STRIDE;
                r = $random(seed);
                write_reg(b + int'(ROT_OFS_CMD), r[7:0]);
                current_angle[ch] = ~current_angle[ch];  // Angle moves on after capture
                tick();
                read_check(b + int'(ROT_OFS_ANGLE_LO));
                read_check(b + int'(ROT_OFS_CMD));
            end
        end

        checking = 1'b0;
        $display("TEST PASSED");
        $finish;
    end

endmodule

// File: src.f
+incdir+.
motor_regs_pkg.sv
drive_channel_regs.sv
rotation_channel_regs.sv
motor_reg_file.sv
tb_motor_reg_file.sv

// File: run_sim.sh
#!/bin/sh
# Build the register file testbench with Verilator, run it and scan the log

rm -f sim.log
verilator --binary --timing -Wno-fatal --top-module tb_motor_reg_file \
    -f src.f -Mdir obj_dir -o sim_tb \
    && ./obj_dir/sim_tb > sim.log 2>&1
cat sim.log 2>/dev/null
[ -f sim.log ] || { echo "Build failed, no simulation log"; exit 1; }
grep -q "TEST FAILED" sim.log && { echo "Simulation reported failure"; exit 1; }
grep -q "TEST PASSED" sim.log || { echo "Simulation ended without a result"; exit 1; }
echo "Simulation passed"
exit 0
